// ==== cnn_pkg.sv ====
////////////////////////////////////////
// cnn_pkg
// tile geometry and on-chip buffer types
// for the conv accelerator tile loader
////////////////////////////////////////

package cnn_pkg;

    localparam int TM = 4;                          // input channels per tile
    localparam int TR = 4;                          // rows per slice
    localparam int TC = 4;                          // cols per slice
    localparam int SLICE_SIZE = TR * TC;            // words per channel slice
    localparam int FM_TILE_SIZE = TM * SLICE_SIZE;  // words per fm tile
    localparam int FM_BANKS = TM;                   // one bank per channel
    localparam int WT_TILE_SIZE = 32;               // words per weight tile
    localparam int DATA_W = 16;

    // issue counters must reach the full tile size
    localparam int FM_CNT_W = $clog2(FM_TILE_SIZE + 1);
    localparam int WT_CNT_W = $clog2(WT_TILE_SIZE + 1);

    typedef logic [DATA_W-1:0]                   data_t;
    typedef logic [$clog2(SLICE_SIZE)-1:0]       fm_addr_t;   // fm bank address
    typedef logic [$clog2(WT_TILE_SIZE)-1:0]     wt_addr_t;   // weight bank address
    typedef logic [FM_CNT_W-1:0]                 fm_cnt_t;
    typedef logic [WT_CNT_W-1:0]                 wt_cnt_t;

endpackage

// ==== fm_bank.sv ====
////////////////////////////////////////
// fm_bank
// single write, single read memory bank
// with a registered read port
////////////////////////////////////////

`timescale 1ns/1ns

module fm_bank #(
    parameter int DEPTH_W = $bits(cnn_pkg::fm_addr_t)   // address width
) (
    input  logic                clk,
    input  logic                wr_en,
    input  logic [DEPTH_W-1:0]  wr_addr,
    input  cnn_pkg::data_t      wr_data,
    input  logic [DEPTH_W-1:0]  rd_addr,
    output cnn_pkg::data_t      rd_data
);

    cnn_pkg::data_t mem [2**DEPTH_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];   // one cycle read latency
    end

endmodule

// ==== in_fm_buffer.sv ====
////////////////////////////////////////
// in_fm_buffer
// loads one fm tile into four banks, one
// channel slice per bank, four read ports
////////////////////////////////////////

`timescale 1ns/1ns

module in_fm_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_start,
    input  mem_pkg::mem_addr_t base_addr,
    output logic               load_done,
    output logic               req,
    output mem_pkg::mem_addr_t req_addr,
    input  logic               gnt,
    input  logic               ret_valid,
    input  cnn_pkg::data_t     ret_data,
    input  cnn_pkg::fm_addr_t  rd_addr0,
    input  cnn_pkg::fm_addr_t  rd_addr1,
    input  cnn_pkg::fm_addr_t  rd_addr2,
    input  cnn_pkg::fm_addr_t  rd_addr3,
    output cnn_pkg::data_t     rd_data0,
    output cnn_pkg::data_t     rd_data1,
    output cnn_pkg::data_t     rd_data2,
    output cnn_pkg::data_t     rd_data3
);

    logic                         busy;
    logic                         start_ok;
    cnn_pkg::fm_cnt_t             issue_cnt;
    cnn_pkg::fm_addr_t            slice_cnt;
    logic [cnn_pkg::FM_BANKS-1:0] bank_sel;
    logic                         slice_end;
    logic                         last_word;
    cnn_pkg::fm_addr_t            bank_rd_addr [cnn_pkg::FM_BANKS];
    cnn_pkg::data_t               bank_rd_data [cnn_pkg::FM_BANKS];

    assign start_ok = load_start && !busy;   // start while busy is dropped

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start_ok) begin
            busy <= 1'b1;
        end else if (last_word) begin
            busy <= 1'b0;
        end
    end

    // issue side, one word per grant
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_cnt <= '0;
            req_addr  <= '0;
        end else if (start_ok) begin
            issue_cnt <= '0;
            req_addr  <= base_addr;
        end else if (gnt) begin
            issue_cnt <= issue_cnt + 1'b1;
            req_addr  <= req_addr + 1'b1;   // linear burst
        end
    end

    assign req = busy && (issue_cnt != cnn_pkg::fm_cnt_t'(cnn_pkg::FM_TILE_SIZE));

    // return side: slice word counter and rotating bank select
    assign slice_end = (slice_cnt == cnn_pkg::fm_addr_t'(cnn_pkg::SLICE_SIZE - 1));
    assign last_word = ret_valid && slice_end && bank_sel[cnn_pkg::FM_BANKS-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slice_cnt <= '0;
            bank_sel  <= {{(cnn_pkg::FM_BANKS-1){1'b0}}, 1'b1};   // bank 0
        end else if (start_ok) begin
            slice_cnt <= '0;
            bank_sel  <= {{(cnn_pkg::FM_BANKS-1){1'b0}}, 1'b1};
        end else if (ret_valid) begin
            if (slice_end) begin
                slice_cnt <= '0;
                bank_sel  <= {bank_sel[cnn_pkg::FM_BANKS-2:0],
                              bank_sel[cnn_pkg::FM_BANKS-1]};   // next channel
            end else begin
                slice_cnt <= slice_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_done <= 1'b0;
        end else begin
            load_done <= last_word;   // cycle after last write
        end
    end

    assign bank_rd_addr[0] = rd_addr0;
    assign bank_rd_addr[1] = rd_addr1;
    assign bank_rd_addr[2] = rd_addr2;
    assign bank_rd_addr[3] = rd_addr3;

    for (genvar b = 0; b < cnn_pkg::FM_BANKS; b++) begin : g_bank
        fm_bank u_fm_bank (
            .clk     (clk),
            .wr_en   (ret_valid && bank_sel[b]),
            .wr_addr (slice_cnt),
            .wr_data (ret_data),
            .rd_addr (bank_rd_addr[b]),
            .rd_data (bank_rd_data[b])
        );
    end

    assign rd_data0 = bank_rd_data[0];
    assign rd_data1 = bank_rd_data[1];
    assign rd_data2 = bank_rd_data[2];
    assign rd_data3 = bank_rd_data[3];

endmodule

// ==== mem_pkg.sv ====
////////////////////////////////////////
// mem_pkg
// external read port widths, latency
// and requester ids
////////////////////////////////////////

package mem_pkg;

    localparam int MEM_AW = 12;    // external word address width
    localparam int MEM_LAT = 2;    // fixed read latency in cycles

    typedef logic [MEM_AW-1:0] mem_addr_t;

    // who issued a read, used to route the return
    typedef logic req_id_t;

    localparam req_id_t REQ_FM = 1'b0;   // feature map loader
    localparam req_id_t REQ_WT = 1'b1;   // weight loader

endpackage

// ==== mem_read_arbiter.sv ====
////////////////////////////////////////
// mem_read_arbiter
// round-robin share of the external read
// port, routes returns to the requester
////////////////////////////////////////

`timescale 1ns/1ns

module mem_read_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic               fm_req,
    input  mem_pkg::mem_addr_t fm_addr,
    output logic               fm_gnt,
    input  logic               wt_req,
    input  mem_pkg::mem_addr_t wt_addr,
    output logic               wt_gnt,
    output logic               fm_ret_valid,
    output logic               wt_ret_valid,
    output cnn_pkg::data_t     ret_data,
    output logic               mem_rd_req,
    output mem_pkg::mem_addr_t mem_rd_addr,
    input  logic               mem_rd_valid,
    input  cnn_pkg::data_t     mem_rd_data
);

    mem_pkg::req_id_t            last_id;
    mem_pkg::req_id_t            gnt_id;
    logic [mem_pkg::MEM_LAT-1:0] pend_vld;
    mem_pkg::req_id_t            pend_id [mem_pkg::MEM_LAT];
    logic                        ret_hit;

    // on a tie the side not granted last wins
    assign fm_gnt = fm_req && (!wt_req || (last_id == mem_pkg::REQ_WT));
    assign wt_gnt = wt_req && (!fm_req || (last_id == mem_pkg::REQ_FM));

    assign gnt_id      = wt_gnt ? mem_pkg::REQ_WT : mem_pkg::REQ_FM;
    assign mem_rd_req  = fm_gnt || wt_gnt;
    assign mem_rd_addr = wt_gnt ? wt_addr : fm_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_id <= mem_pkg::REQ_WT;   // fm wins the first tie
        end else if (mem_rd_req) begin
            last_id <= gnt_id;
        end
    end

    // in-flight tracking, one stage per cycle of read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_vld <= '0;
        end else begin
            pend_vld[0] <= mem_rd_req;
            for (int i = 1; i < mem_pkg::MEM_LAT; i++) begin
                pend_vld[i] <= pend_vld[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        pend_id[0] <= gnt_id;
        for (int i = 1; i < mem_pkg::MEM_LAT; i++) begin
            pend_id[i] <= pend_id[i-1];
        end
    end

    assign ret_hit = mem_rd_valid && pend_vld[mem_pkg::MEM_LAT-1];

    // data is shared, only the owner sees a strobe
    assign fm_ret_valid = ret_hit && (pend_id[mem_pkg::MEM_LAT-1] == mem_pkg::REQ_FM);
    assign wt_ret_valid = ret_hit && (pend_id[mem_pkg::MEM_LAT-1] == mem_pkg::REQ_WT);
    assign ret_data     = mem_rd_data;

endmodule

// ==== run.sh ====
#!/bin/sh
# compile the tile loader testbench with Verilator and run it
verilator --binary --timing --assert -Wno-fatal --top-module tile_loader_tb -f vlog.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtile_loader_tb)
echo "$out"
echo "$out" | grep -q "All tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb_clk_gen.sv ====
////////////////////////////////////////
// tb_clk_gen
// testbench clock, 20 ns period, and a
// reset held for the first 5 cycles
////////////////////////////////////////

`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;   // release away from the active edge
    end

endmodule

// ==== tile_loader_chk.sv ====
////////////////////////////////////////
// tile_loader_chk
// protocol assertions on the external
// read port arbiter
////////////////////////////////////////

`timescale 1ns/1ns

module tile_loader_chk (
    input logic clk,
    input logic rst,
    input logic fm_req,
    input logic fm_gnt,
    input logic wt_req,
    input logic wt_gnt,
    input logic mem_rd_req,
    input logic fm_ret_valid,
    input logic wt_ret_valid
);

    a_one_gnt: assert property (@(posedge clk) disable iff (rst) !(fm_gnt && wt_gnt))
        else $error("fm and weight grants high in the same cycle");

    a_fm_gnt_req: assert property (@(posedge clk) disable iff (rst) fm_gnt |-> fm_req)
        else $error("fm grant without fm request");

    a_wt_gnt_req: assert property (@(posedge clk) disable iff (rst) wt_gnt |-> wt_req)
        else $error("weight grant without weight request");

    // one external read per grant, none otherwise
    a_rd_req: assert property (@(posedge clk) disable iff (rst)
        mem_rd_req == (fm_gnt || wt_gnt))
        else $error("mem_rd_req does not follow the grants");

    a_one_ret: assert property (@(posedge clk) disable iff (rst)
        !(fm_ret_valid && wt_ret_valid))
        else $error("return routed to both loaders");

endmodule

bind mem_read_arbiter tile_loader_chk u_tile_loader_chk (
    .clk          (clk),
    .rst          (rst),
    .fm_req       (fm_req),
    .fm_gnt       (fm_gnt),
    .wt_req       (wt_req),
    .wt_gnt       (wt_gnt),
    .mem_rd_req   (mem_rd_req),
    .fm_ret_valid (fm_ret_valid),
    .wt_ret_valid (wt_ret_valid)
);

// ==== tile_loader_tb.sv ====
////////////////////////////////////////
// tile_loader_tb
// runs fm and weight tile loads against a
// memory model and reads the buffers back
////////////////////////////////////////

`timescale 1ns/1ns

module tile_loader_tb;

    localparam int LOAD_TIMEOUT = 400;               // cycles per load wait
    localparam int MEM_WORDS = 2**mem_pkg::MEM_AW;

    logic               clk;
    logic               rst;
    logic               fm_load_start;
    mem_pkg::mem_addr_t fm_base_addr;
    logic               fm_load_done;
    logic               wt_load_start;
    mem_pkg::mem_addr_t wt_base_addr;
    logic               wt_load_done;
    logic               mem_rd_req;
    mem_pkg::mem_addr_t mem_rd_addr;
    logic               mem_rd_valid;
    cnn_pkg::data_t     mem_rd_data;
    cnn_pkg::fm_addr_t  fm_rd_addr0;
    cnn_pkg::fm_addr_t  fm_rd_addr1;
    cnn_pkg::fm_addr_t  fm_rd_addr2;
    cnn_pkg::fm_addr_t  fm_rd_addr3;
    cnn_pkg::data_t     fm_rd_data0;
    cnn_pkg::data_t     fm_rd_data1;
    cnn_pkg::data_t     fm_rd_data2;
    cnn_pkg::data_t     fm_rd_data3;
    cnn_pkg::wt_addr_t  wt_rd_addr;
    cnn_pkg::data_t     wt_rd_data;

    cnn_pkg::data_t             mem_model [MEM_WORDS];
    logic [mem_pkg::MEM_AW:0]   pipe_q [$];   // {valid, addr} per cycle

    // written by the monitor only
    int req_total = 0;
    int fm_total = 0;
    int wt_total = 0;
    int fm_done_total = 0;
    int wt_done_total = 0;
    int last_side = -1;
    int alt_errors = 0;

    // written by the test only
    int  req_mark = 0;
    int  fm_mark = 0;
    int  wt_mark = 0;
    int  fm_done_mark = 0;
    int  wt_done_mark = 0;
    bit  alt_check = 1'b0;
    int  errors = 0;
    int  checks = 0;

    tb_clk_gen u_tb_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    tile_loader_top u_tile_loader_top (
        .clk           (clk),
        .rst           (rst),
        .fm_load_start (fm_load_start),
        .fm_base_addr  (fm_base_addr),
        .fm_load_done  (fm_load_done),
        .wt_load_start (wt_load_start),
        .wt_base_addr  (wt_base_addr),
        .wt_load_done  (wt_load_done),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rd_valid  (mem_rd_valid),
        .mem_rd_data   (mem_rd_data),
        .fm_rd_addr0   (fm_rd_addr0),
        .fm_rd_addr1   (fm_rd_addr1),
        .fm_rd_addr2   (fm_rd_addr2),
        .fm_rd_addr3   (fm_rd_addr3),
        .fm_rd_data0   (fm_rd_data0),
        .fm_rd_data1   (fm_rd_data1),
        .fm_rd_data2   (fm_rd_data2),
        .fm_rd_data3   (fm_rd_data3),
        .wt_rd_addr    (wt_rd_addr),
        .wt_rd_data    (wt_rd_data)
    );

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // expected buffer word taken straight from the memory model
    function automatic cnn_pkg::data_t expected_word(input bit is_wt, input int bank,
                                                     input int addr,
                                                     input mem_pkg::mem_addr_t base);
        mem_pkg::mem_addr_t a;
        if (is_wt) begin
            a = mem_pkg::mem_addr_t'(int'(base) + addr);
        end else begin
            a = mem_pkg::mem_addr_t'(int'(base) + cnn_pkg::SLICE_SIZE * bank + addr);
        end
        return mem_model[a];
    endfunction

    task automatic fill_memory();
        logic [31:0]    state;
        cnn_pkg::data_t word;
        state = 32'hb2d306dd;
        for (int i = 0; i < MEM_WORDS; i++) begin
            for (int b = 0; b < cnn_pkg::DATA_W; b++) begin
                state = lfsr_next(state);
                word[b] = state[0];   // one step per bit
            end
            mem_model[i] = word;
        end
    endtask

    // responder and monitor on the falling edge where outputs are settled
    always @(negedge clk) begin
        logic [mem_pkg::MEM_AW:0] entry;
        int                       side;
        pipe_q.push_back({mem_rd_req, mem_rd_addr});
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
        if (pipe_q.size() > mem_pkg::MEM_LAT) begin
            entry = pipe_q.pop_front();
            if (entry[mem_pkg::MEM_AW]) begin
                mem_rd_valid = 1'b1;
                mem_rd_data  = mem_model[entry[mem_pkg::MEM_AW-1:0]];
            end
        end
        if (!rst) begin
            if (mem_rd_req) begin
                req_total++;
                side = 1;
                if (int'(mem_rd_addr) >= int'(fm_base_addr) &&
                    int'(mem_rd_addr) < int'(fm_base_addr) + cnn_pkg::FM_TILE_SIZE) begin
                    side = 0;
                end
                if (alt_check && side == last_side &&
                    fm_total - fm_mark < cnn_pkg::FM_TILE_SIZE &&
                    wt_total - wt_mark < cnn_pkg::WT_TILE_SIZE) begin
                    alt_errors++;
                    $display("at %0t ns one loader got two grants in a row while both requested",
                             $time);
                end
                if (side == 0) begin
                    fm_total++;
                end else begin
                    wt_total++;
                end
                last_side = side;
            end else begin
                last_side = -1;   // idle gap breaks the sequence
            end
            if (fm_load_done) begin
                fm_done_total++;
            end
            if (wt_load_done) begin
                wt_done_total++;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic mark_counts();
        req_mark     = req_total;
        fm_mark      = fm_total;
        wt_mark      = wt_total;
        fm_done_mark = fm_done_total;
        wt_done_mark = wt_done_total;
    endtask

    task automatic start_loads(input bit do_fm, input bit do_wt);
        @(negedge clk);
        fm_load_start = do_fm;
        wt_load_start = do_wt;
        @(negedge clk);
        fm_load_start = 1'b0;
        wt_load_start = 1'b0;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            errors++;
            $display("reset was never released");
        end
    endtask

    task automatic wait_done(input int fm_target, input int wt_target);
        int n;
        n = 0;
        while ((fm_done_total - fm_done_mark < fm_target ||
                wt_done_total - wt_done_mark < wt_target) && n < LOAD_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= LOAD_TIMEOUT) begin
            errors++;
            $display("timeout at %0t ns, a tile load did not finish", $time);
        end
        repeat (8) @(negedge clk);   // room for stray pulses
    endtask

    task automatic check_counts(input int reqs, input int fm_dones, input int wt_dones);
        check_value("mem_rd_req count", reqs, req_total - req_mark);
        check_value("fm_load_done count", fm_dones, fm_done_total - fm_done_mark);
        check_value("wt_load_done count", wt_dones, wt_done_total - wt_done_mark);
    endtask

    // all four banks read in the same cycle at staggered addresses
    task automatic read_back_fm(input mem_pkg::mem_addr_t base);
        cnn_pkg::fm_addr_t a0;
        cnn_pkg::fm_addr_t a1;
        cnn_pkg::fm_addr_t a2;
        cnn_pkg::fm_addr_t a3;
        for (int a = 0; a < cnn_pkg::SLICE_SIZE; a++) begin
            a0 = cnn_pkg::fm_addr_t'(a);
            a1 = cnn_pkg::fm_addr_t'(a + 5);
            a2 = cnn_pkg::fm_addr_t'(a + 10);
            a3 = cnn_pkg::fm_addr_t'(a + 15);
            @(negedge clk);
            fm_rd_addr0 = a0;
            fm_rd_addr1 = a1;
            fm_rd_addr2 = a2;
            fm_rd_addr3 = a3;
            @(negedge clk);
            check_value($sformatf("fm_rd_data0[%0d]", a0), expected_word(0, 0, a0, base),
                        fm_rd_data0);
            check_value($sformatf("fm_rd_data1[%0d]", a1), expected_word(0, 1, a1, base),
                        fm_rd_data1);
            check_value($sformatf("fm_rd_data2[%0d]", a2), expected_word(0, 2, a2, base),
                        fm_rd_data2);
            check_value($sformatf("fm_rd_data3[%0d]", a3), expected_word(0, 3, a3, base),
                        fm_rd_data3);
        end
    endtask

    task automatic read_back_wt(input mem_pkg::mem_addr_t base);
        for (int a = 0; a < cnn_pkg::WT_TILE_SIZE; a++) begin
            @(negedge clk);
            wt_rd_addr = cnn_pkg::wt_addr_t'(a);
            @(negedge clk);
            check_value($sformatf("wt_rd_data[%0d]", a), expected_word(1, 0, a, base),
                        wt_rd_data);
        end
    endtask

    initial begin
        fm_load_start = 1'b0;
        wt_load_start = 1'b0;
        fm_base_addr  = '0;
        wt_base_addr  = '0;
        mem_rd_valid  = 1'b0;
        mem_rd_data   = '0;
        fm_rd_addr0   = '0;
        fm_rd_addr1   = '0;
        fm_rd_addr2   = '0;
        fm_rd_addr3   = '0;
        wt_rd_addr    = '0;
        fill_memory();
        wait_reset();

        mark_counts();
        repeat (10) @(negedge clk);   // quiet after reset
        check_counts(0, 0, 0);

        fm_base_addr = 12'h100;
        mark_counts();
        start_loads(1'b1, 1'b0);
        wait_done(1, 0);
        check_counts(cnn_pkg::FM_TILE_SIZE, 1, 0);
        read_back_fm(12'h100);

        wt_base_addr = 12'h800;
        mark_counts();
        start_loads(1'b0, 1'b1);
        wait_done(0, 1);
        check_counts(cnn_pkg::WT_TILE_SIZE, 0, 1);
        read_back_wt(12'h800);

        // both loaders contend for the port
        fm_base_addr = 12'h240;
        wt_base_addr = 12'hA10;
        mark_counts();
        alt_check = 1'b1;
        start_loads(1'b1, 1'b1);
        wait_done(1, 1);
        alt_check = 1'b0;
        check_counts(cnn_pkg::FM_TILE_SIZE + cnn_pkg::WT_TILE_SIZE, 1, 1);
        read_back_fm(12'h240);
        read_back_wt(12'hA10);

        // a start during a load is dropped
        fm_base_addr = 12'h300;
        mark_counts();
        start_loads(1'b1, 1'b0);
        repeat (10) @(negedge clk);
        fm_base_addr = 12'h700;
        start_loads(1'b1, 1'b0);
        wait_done(1, 0);
        check_counts(cnn_pkg::FM_TILE_SIZE, 1, 0);
        read_back_fm(12'h300);

        mark_counts();
        start_loads(1'b1, 1'b0);
        wait_done(1, 0);
        check_counts(cnn_pkg::FM_TILE_SIZE, 1, 0);
        read_back_fm(12'h700);

        $display("%0d checks, %0d errors", checks, errors + alt_errors);
        if (errors + alt_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tile_loader_top.sv ====
////////////////////////////////////////
// tile_loader_top
// fm and weight loaders sharing one
// external read port
////////////////////////////////////////

`timescale 1ns/1ns

module tile_loader_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               fm_load_start,
    input  mem_pkg::mem_addr_t fm_base_addr,
    output logic               fm_load_done,
    input  logic               wt_load_start,
    input  mem_pkg::mem_addr_t wt_base_addr,
    output logic               wt_load_done,
    output logic               mem_rd_req,
    output mem_pkg::mem_addr_t mem_rd_addr,
    input  logic               mem_rd_valid,
    input  cnn_pkg::data_t     mem_rd_data,
    input  cnn_pkg::fm_addr_t  fm_rd_addr0,
    input  cnn_pkg::fm_addr_t  fm_rd_addr1,
    input  cnn_pkg::fm_addr_t  fm_rd_addr2,
    input  cnn_pkg::fm_addr_t  fm_rd_addr3,
    output cnn_pkg::data_t     fm_rd_data0,
    output cnn_pkg::data_t     fm_rd_data1,
    output cnn_pkg::data_t     fm_rd_data2,
    output cnn_pkg::data_t     fm_rd_data3,
    input  cnn_pkg::wt_addr_t  wt_rd_addr,
    output cnn_pkg::data_t     wt_rd_data
);

    logic               fm_req;
    mem_pkg::mem_addr_t fm_req_addr;
    logic               fm_gnt;
    logic               fm_ret_valid;
    logic               wt_req;
    mem_pkg::mem_addr_t wt_req_addr;
    logic               wt_gnt;
    logic               wt_ret_valid;
    cnn_pkg::data_t     ret_data;     // shared return bus

    in_fm_buffer u_in_fm_buffer (
        .clk        (clk),
        .rst        (rst),
        .load_start (fm_load_start),
        .base_addr  (fm_base_addr),
        .load_done  (fm_load_done),
        .req        (fm_req),
        .req_addr   (fm_req_addr),
        .gnt        (fm_gnt),
        .ret_valid  (fm_ret_valid),
        .ret_data   (ret_data),
        .rd_addr0   (fm_rd_addr0),
        .rd_addr1   (fm_rd_addr1),
        .rd_addr2   (fm_rd_addr2),
        .rd_addr3   (fm_rd_addr3),
        .rd_data0   (fm_rd_data0),
        .rd_data1   (fm_rd_data1),
        .rd_data2   (fm_rd_data2),
        .rd_data3   (fm_rd_data3)
    );

    weight_buffer u_weight_buffer (
        .clk        (clk),
        .rst        (rst),
        .load_start (wt_load_start),
        .base_addr  (wt_base_addr),
        .load_done  (wt_load_done),
        .req        (wt_req),
        .req_addr   (wt_req_addr),
        .gnt        (wt_gnt),
        .ret_valid  (wt_ret_valid),
        .ret_data   (ret_data),
        .rd_addr    (wt_rd_addr),
        .rd_data    (wt_rd_data)
    );

    mem_read_arbiter u_mem_read_arbiter (
        .clk          (clk),
        .rst          (rst),
        .fm_req       (fm_req),
        .fm_addr      (fm_req_addr),
        .fm_gnt       (fm_gnt),
        .wt_req       (wt_req),
        .wt_addr      (wt_req_addr),
        .wt_gnt       (wt_gnt),
        .fm_ret_valid (fm_ret_valid),
        .wt_ret_valid (wt_ret_valid),
        .ret_data     (ret_data),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data)
    );

endmodule

// ==== vlog.f ====
cnn_pkg.sv
mem_pkg.sv
fm_bank.sv
in_fm_buffer.sv
weight_buffer.sv
mem_read_arbiter.sv
tile_loader_top.sv
tb_clk_gen.sv
tile_loader_chk.sv
tile_loader_tb.sv

// ==== weight_buffer.sv ====
////////////////////////////////////////
// weight_buffer
// loads one weight tile into a single
// bank, one read port
////////////////////////////////////////

`timescale 1ns/1ns

module weight_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_start,
    input  mem_pkg::mem_addr_t base_addr,
    output logic               load_done,
    output logic               req,
    output mem_pkg::mem_addr_t req_addr,
    input  logic               gnt,
    input  logic               ret_valid,
    input  cnn_pkg::data_t     ret_data,
    input  cnn_pkg::wt_addr_t  rd_addr,
    output cnn_pkg::data_t     rd_data
);

    logic              busy;
    logic              start_ok;
    cnn_pkg::wt_cnt_t  issue_cnt;
    cnn_pkg::wt_addr_t wr_addr;
    logic              last_word;

    assign start_ok  = load_start && !busy;
    assign last_word = ret_valid && (wr_addr == cnn_pkg::wt_addr_t'(cnn_pkg::WT_TILE_SIZE - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start_ok) begin
            busy <= 1'b1;
        end else if (last_word) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_cnt <= '0;
            req_addr  <= '0;
            wr_addr   <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= last_word;
            if (start_ok) begin
                issue_cnt <= '0;
                req_addr  <= base_addr;
                wr_addr   <= '0;
            end else begin
                if (gnt) begin
                    issue_cnt <= issue_cnt + 1'b1;
                    req_addr  <= req_addr + 1'b1;
                end
                if (ret_valid) begin
                    wr_addr <= wr_addr + 1'b1;   // linear fill
                end
            end
        end
    end

    assign req = busy && (issue_cnt != cnn_pkg::wt_cnt_t'(cnn_pkg::WT_TILE_SIZE));

    fm_bank #(
        .DEPTH_W ($bits(cnn_pkg::wt_addr_t))
    ) u_wt_bank (
        .clk     (clk),
        .wr_en   (ret_valid),
        .wr_addr (wr_addr),
        .wr_data (ret_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule
